/* hdl/sram_params.svh */
`ifndef SRAM_PARAMS_SVH
`define SRAM_PARAMS_SVH

// --------------------
// Bank geometry
// --------------------
`define SRAM_BANK_ABITS 10                  // Word address bits per bank

// --------------------
// Data path
// --------------------
`define SRAM_DATA_BITS  32                  // Word width
`define SRAM_BYTES      (`SRAM_DATA_BITS/8) // Byte lanes per word

// --------------------
// Timing
// --------------------
`define SRAM_READ_LAT   1                   // Cycles from strobe to ack

`endif

/* hdl/sram_pkg.sv */
`include "sram_params.svh"

package sram_pkg;

   // --------------------
   // Data path types
   // --------------------
   typedef logic [`SRAM_DATA_BITS-1:0] word_t;      // One data word
   typedef logic [`SRAM_BYTES-1:0]     sel_t;       // Byte-lane selects

   // --------------------
   // Address types
   // --------------------
   typedef logic [`SRAM_BANK_ABITS-1:0] bank_adr_t; // Word address inside a bank
   typedef logic [`SRAM_BANK_ABITS:0]   bus_adr_t;  // MSB picks the bank

endpackage

/* hdl/sram_bus_if.sv */
interface sram_bus_if;
   import sram_pkg::*;

   // --------------------
   // Request side
   // --------------------
   logic      cyc;   // Cycle in progress
   logic      stb;   // Request strobe for this bank
   logic      we;    // Write request
   bank_adr_t adr;   // Word address in bank
   sel_t      sel;   // Byte lanes
   word_t     dat_w; // Write data

   // --------------------
   // Response side
   // --------------------
   logic      ack;   // One pulse per request
   word_t     dat_r; // Read data, valid with ack

   // Request steering end
   modport decoder (
      output cyc, stb, we, adr, sel, dat_w,
      input  ack, dat_r
   );

   // Bank channel end
   modport channel (
      input  cyc, stb, we, adr, sel, dat_w,
      output ack, dat_r
   );

endinterface

/* hdl/sram_bank.sv */
`include "sram_params.svh"

module sram_bank (
   input  logic                clk_i,
   input  logic                ce_i,  // Chip enable
   input  logic                we_i,  // Write enable
   input  sram_pkg::bank_adr_t adr_i, // Word address
   input  sram_pkg::sel_t      bes_i, // Byte write enables
   input  sram_pkg::word_t     dat_i, // Write data
   output sram_pkg::word_t     dat_o  // Registered read data
);
   import sram_pkg::*;

   localparam int DEPTH = 2 ** `SRAM_BANK_ABITS; // Words per bank

   // --------------------
   // Storage
   // --------------------
   word_t mem [DEPTH];

   // Write lanes flagged in bes_i
   always_ff @(posedge clk_i) begin
      if (ce_i && we_i) begin
         for (int b = 0; b < `SRAM_BYTES; b++) begin
            if (bes_i[b]) begin
               mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8]; // One byte lane
            end
         end
      end
   end

   // --------------------
   // Read port
   // --------------------
   // A read in the same cycle as a write to the same word returns the
   // old contents, as a plain single-port array would
   always_ff @(posedge clk_i) begin
      if (ce_i) begin
         dat_o <= mem[adr_i];                            // Held while disabled
      end
   end

endmodule

/* hdl/wb_sram_interface.sv */
`include "sram_params.svh"

module wb_sram_interface (
   input  logic                clk_i,
   input  logic                rst_i,
   sram_bus_if.channel         bus,        // Bank channel from the decoder
   output logic                sram_ce_o,  // Chip enable
   output logic                sram_we_o,  // Write enable
   output sram_pkg::bank_adr_t sram_adr_o,
   output sram_pkg::sel_t      sram_bes_o, // Byte write enables
   output sram_pkg::word_t     sram_dat_o, // Write data to the array
   input  sram_pkg::word_t     sram_dat_i  // Read data from the array
);

   // --------------------
   // Ack pipeline
   // --------------------
   logic [`SRAM_READ_LAT-1:0] ack_q;   // One stage per read cycle
   logic [`SRAM_READ_LAT:0]   ack_nxt; // Shifted in from the strobe

   assign ack_nxt = {ack_q, bus.cyc & bus.stb};

   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_q <= '0;                               // No ack in flight
      end else begin
         ack_q <= ack_nxt[`SRAM_READ_LAT-1:0];
      end
   end

   assign bus.ack   = ack_nxt[`SRAM_READ_LAT];     // Oldest stage leaves
   assign bus.dat_r = sram_dat_i;                 // Array output is already registered

   // --------------------
   // SRAM line drivers
   // --------------------
   assign sram_ce_o  = bus.cyc;                   // Enabled for the whole cycle
   assign sram_we_o  = bus.we & bus.stb;          // Only when this bank is strobed
   assign sram_adr_o = bus.adr;
   assign sram_bes_o = {`SRAM_BYTES{sram_we_o}} & bus.sel; // Lanes gated by write
   assign sram_dat_o = bus.dat_w;

endmodule

/* hdl/bank_decoder.sv */
`include "sram_params.svh"

module bank_decoder (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               cyc_i,
   input  logic               stb_i,
   input  logic               we_i,
   input  sram_pkg::bus_adr_t adr_i, // MSB selects the bank
   input  sram_pkg::sel_t     sel_i,
   input  sram_pkg::word_t    dat_i,
   output logic               ack_o,
   output sram_pkg::word_t    dat_o,
   sram_bus_if.decoder        bus0,  // Bank 0 channel
   sram_bus_if.decoder        bus1   // Bank 1 channel
);

   // --------------------
   // Request steering
   // --------------------
   logic req;      // Request accepted this cycle
   logic bank_sel; // Bank named by the address
   logic bank_q;   // Bank of the request in flight

   assign req      = cyc_i & stb_i;
   assign bank_sel = adr_i[`SRAM_BANK_ABITS];   // Top address bit

   // Shared request lines to both banks
   assign bus0.cyc   = cyc_i;
   assign bus0.we    = we_i;
   assign bus0.adr   = adr_i[`SRAM_BANK_ABITS-1:0];
   assign bus0.sel   = sel_i;
   assign bus0.dat_w = dat_i;

   assign bus1.cyc   = cyc_i;
   assign bus1.we    = we_i;
   assign bus1.adr   = adr_i[`SRAM_BANK_ABITS-1:0];
   assign bus1.sel   = sel_i;
   assign bus1.dat_w = dat_i;

   // Strobe reaches only the addressed bank
   assign bus0.stb = stb_i & ~bank_sel;
   assign bus1.stb = stb_i & bank_sel;

   // --------------------
   // Response merge
   // --------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         bank_q <= 1'b0;
      end else if (req) begin
         bank_q <= bank_sel;                      // Remember who answers next cycle
      end
   end

   // Responses come back in request order since both banks share one latency
   always_comb begin
      if (bank_q) begin
         ack_o = bus1.ack;
         dat_o = bus1.dat_r;
      end else begin
         ack_o = bus0.ack;
         dat_o = bus0.dat_r;
      end
   end

endmodule

/* hdl/dual_bank_sram.sv */
module dual_bank_sram (
   input  logic               clk_i,
   input  logic               rst_i,
   input  logic               cyc_i,
   input  logic               stb_i,
   input  logic               we_i,
   input  sram_pkg::bus_adr_t adr_i, // Word address, MSB picks the bank
   input  sram_pkg::sel_t     sel_i, // Byte lanes for writes
   input  sram_pkg::word_t    dat_i,
   output logic               ack_o, // One cycle after each request
   output sram_pkg::word_t    dat_o  // Read data, valid with ack_o
);
   import sram_pkg::*;

   // --------------------
   // Bank channels
   // --------------------
   sram_bus_if bus0 ();
   sram_bus_if bus1 ();

   // Array lines for bank 0
   logic      ce0, we0;
   bank_adr_t adr0;
   sel_t      bes0;
   word_t     wdat0, rdat0;

   // Array lines for bank 1
   logic      ce1, we1;
   bank_adr_t adr1;
   sel_t      bes1;
   word_t     wdat1, rdat1;

   bank_decoder bank_decoder_inst (
      .clk_i (clk_i), .rst_i (rst_i),
      .cyc_i (cyc_i), .stb_i (stb_i), .we_i (we_i),
      .adr_i (adr_i), .sel_i (sel_i), .dat_i (dat_i),
      .ack_o (ack_o), .dat_o (dat_o),
      .bus0  (bus0),  .bus1  (bus1)
   );

   // --------------------
   // Bank 0
   // --------------------
   wb_sram_interface wb_sram_interface_0 (
      .clk_i      (clk_i), .rst_i (rst_i), .bus (bus0),
      .sram_ce_o  (ce0),   .sram_we_o  (we0),   .sram_adr_o (adr0),
      .sram_bes_o (bes0),  .sram_dat_o (wdat0), .sram_dat_i (rdat0)
   );

   sram_bank sram_bank_0 (
      .clk_i (clk_i), .ce_i  (ce0),  .we_i  (we0),  .adr_i (adr0),
      .bes_i (bes0),  .dat_i (wdat0), .dat_o (rdat0)
   );

   // --------------------
   // Bank 1
   // --------------------
   wb_sram_interface wb_sram_interface_1 (
      .clk_i      (clk_i), .rst_i (rst_i), .bus (bus1),
      .sram_ce_o  (ce1),   .sram_we_o  (we1),   .sram_adr_o (adr1),
      .sram_bes_o (bes1),  .sram_dat_o (wdat1), .sram_dat_i (rdat1)
   );

   sram_bank sram_bank_1 (
      .clk_i (clk_i), .ce_i  (ce1),  .we_i  (we1),  .adr_i (adr1),
      .bes_i (bes1),  .dat_i (wdat1), .dat_o (rdat1)
   );

endmodule

/* verification/dual_bank_sram_sva.sv */
module dual_bank_sram_sva (
   input logic clk_i,
   input logic rst_i,
   input logic cyc_i,
   input logic stb_i,
   input logic ack_i   // Merged ack from the decoder
);
   timeunit 1ns;
   timeprecision 1ps;

   logic req;                  // Request accepted at this edge
   bit   assert_failed = 1'b0; // Raised by any failing property

   assign req = cyc_i & stb_i;

   // --------------------
   // Ack timing
   // --------------------
   ack_follows_req: assert property (
      @(posedge clk_i) disable iff (rst_i) req |=> ack_i
   ) else begin
      assert_failed = 1'b1;
      $error("ack missing one cycle after an accepted request");
   end

   ack_needs_req: assert property (
      @(posedge clk_i) disable iff (rst_i) ack_i |-> $past(req)
   ) else begin
      assert_failed = 1'b1;
      $error("ack raised with no request in the previous cycle");
   end

   // Reset clears the ack stage at every edge
   ack_low_in_reset: assert property (
      @(posedge clk_i) $past(rst_i) |-> !ack_i
   ) else begin
      assert_failed = 1'b1;
      $error("ack high while reset was applied");
   end

endmodule

bind bank_decoder dual_bank_sram_sva dual_bank_sram_sva_inst (
   .clk_i (clk_i), .rst_i (rst_i), .cyc_i (cyc_i), .stb_i (stb_i), .ack_i (ack_o)
);

/* verification/dual_bank_sram_tb.sv */
`include "sram_params.svh"

module dual_bank_sram_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import sram_pkg::*;

   localparam int CLK_PERIOD   = 8;
   localparam int RESET_CYCLES = 10;
   localparam int POOL         = 16;  // Preloaded words per bank
   localparam int PARTIAL_OPS  = 24;  // Write plus read each
   localparam int ALT_OPS      = 16;
   localparam int RANDOM_OPS   = 300;
   localparam int NUM_OPS      = 2*POOL + 4 + 2*PARTIAL_OPS + ALT_OPS + 4 + RANDOM_OPS;
   localparam int SHADOW_WORDS = 2 ** (`SRAM_BANK_ABITS + 1); // Both banks

   typedef struct packed {
      logic  is_read;
      word_t data;         // Expected read word
   } response_t;

   logic     clk_i, rst_i;
   logic     cyc_i, stb_i, we_i;
   bus_adr_t adr_i;
   sel_t     sel_i;
   word_t    dat_i;
   logic     ack_o;
   word_t    dat_o;
   logic     sva_failed;             // Any bound assertion has fired

   word_t     shadow [SHADOW_WORDS]; // Reference copy of both banks
   response_t expected_q [$];        // One entry per accepted request

   dual_bank_sram dual_bank_sram_inst (
      .clk_i (clk_i), .rst_i (rst_i), .cyc_i (cyc_i), .stb_i (stb_i), .we_i (we_i),
      .adr_i (adr_i), .sel_i (sel_i), .dat_i (dat_i), .ack_o (ack_o), .dat_o (dat_o)
   );

   assign sva_failed =
      dual_bank_sram_inst.bank_decoder_inst.dual_bank_sram_sva_inst.assert_failed;

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   // --------------------
   // Reference and checks
   // --------------------
   // Selected lanes take the new byte, the rest keep the old one
   function automatic word_t merge_lanes(input word_t old_w, input word_t new_w, input sel_t sel);
      word_t res;
      res = old_w;
      for (int b = 0; b < `SRAM_BYTES; b++) begin
         if (sel[b]) begin
            res[8*b +: 8] = new_w[8*b +: 8];
         end
      end
      return res;
   endfunction

   // Even index in bank 0, odd in bank 1, pairs share low bits
   function automatic bus_adr_t pool_address(input int idx);
      bank_adr_t low;
      low = bank_adr_t'((idx / 2) * 61 + 5);
      return {idx[0], low};
   endfunction

   task automatic abort_test();
      $display("Test failed");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("ERROR t=%0t %s expected %h actual %h", $time, name, exp, act);
         abort_test();
      end
   endtask

   task automatic check_ack(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("ERROR t=%0t %s expected %b actual %b", $time, name, exp, act);
         abort_test();
      end
   endtask

   // Outputs are all registered, so mid-cycle sampling is stable
   always @(negedge clk_i) begin
      response_t rsp;
      if (sva_failed) begin
         $display("A bound assertion on the decoder failed before %0t", $time);
         abort_test();
      end else if (rst_i) begin
         check_ack("ack_o", 1'b0, ack_o);            // Quiet through reset
      end else if (ack_o && expected_q.size() == 0) begin
         $display("ack_o pulsed at %0t with no request in the previous cycle", $time);
         abort_test();
      end else if (!ack_o && expected_q.size() != 0) begin
         $display("No ack at %0t for the request issued in the previous cycle", $time);
         abort_test();
      end else if (ack_o) begin
         rsp = expected_q.pop_front();
         if (rsp.is_read) begin
            check_word("dat_o", rsp.data, dat_o);    // Writes carry no data back
         end
      end
   end

   // --------------------
   // Bus drivers
   // --------------------
   task automatic issue_request(input logic we, input bus_adr_t adr, input sel_t sel,
                                input word_t dat);
      response_t rsp;
      @(negedge clk_i);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      we_i  = we;
      adr_i = adr;
      sel_i = sel;
      dat_i = dat;
      rsp.is_read = !we;
      rsp.data    = shadow[adr];                     // Value before this write
      if (we) begin
         shadow[adr] = merge_lanes(shadow[adr], dat, sel);
      end
      @(posedge clk_i);                              // Accepting edge
      expected_q.push_back(rsp);
   endtask

   task automatic idle_cycle();
      @(negedge clk_i);
      cyc_i = $urandom_range(1) != 0;                // cyc alone starts nothing
      stb_i = 1'b0;
      we_i  = 1'b0;
      @(posedge clk_i);
   endtask

   // --------------------
   // Test phases
   // --------------------
   task automatic fill_pool();
      for (int i = 0; i < 2*POOL; i++) begin
         issue_request(1'b1, pool_address(i), '1, $urandom());
      end
   endtask

   task automatic smoke_each_bank();
      issue_request(1'b1, pool_address(0), '1, 32'h0bad_cafe); // Bank 0
      issue_request(1'b1, pool_address(1), '1, 32'h1234_5678); // Bank 1
      issue_request(1'b0, pool_address(0), '0, '0);
      issue_request(1'b0, pool_address(1), '0, '0);
   endtask

   task automatic partial_writes();
      bus_adr_t adr;
      for (int i = 0; i < PARTIAL_OPS; i++) begin
         adr = pool_address($urandom_range(2*POOL-1));
         issue_request(1'b1, adr, sel_t'($urandom_range(15)), $urandom());
         issue_request(1'b0, adr, '0, '0);           // Read back the merge
      end
   endtask

   // Back to back, bank flips on every request
   task automatic alternate_banks();
      for (int i = 0; i < ALT_OPS/2; i++) begin
         issue_request(1'b1, pool_address(i), '1, $urandom());
      end
      for (int i = 0; i < ALT_OPS/2; i++) begin
         issue_request(1'b0, pool_address(i), '0, '0);
      end
   endtask

   task automatic bank_independence();
      issue_request(1'b1, pool_address(6), '1, 32'haaaa_0000); // MSB 0
      issue_request(1'b1, pool_address(7), '1, 32'h0000_5555); // Same low bits, MSB 1
      issue_request(1'b0, pool_address(6), '0, '0);
      issue_request(1'b0, pool_address(7), '0, '0);
   endtask

   task automatic random_mix();
      bus_adr_t adr;
      logic     we;
      for (int i = 0; i < RANDOM_OPS; i++) begin
         if ($urandom_range(3) == 0) begin
            idle_cycle();                            // Gap in the traffic
         end
         adr = pool_address($urandom_range(2*POOL-1));
         we  = $urandom_range(1) != 0;
         issue_request(we, adr, sel_t'($urandom_range(15)), $urandom());
      end
   endtask

   // Watchdog sized from the op count
   initial begin
      #((RESET_CYCLES + 2 * NUM_OPS) * CLK_PERIOD);
      $display("Watchdog expired at %0t before all requests finished", $time);
      abort_test();
   end

   initial begin
      void'($urandom(32'he9818a89));
      rst_i = 1'b1;
      cyc_i = 1'b1;                                  // Read strobe held through reset
      stb_i = 1'b1;
      we_i  = 1'b0;
      adr_i = '0;
      sel_i = '0;
      dat_i = '0;
      repeat (RESET_CYCLES) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      repeat (3) idle_cycle();                       // ack stays low after reset
      fill_pool();
      smoke_each_bank();
      partial_writes();
      alternate_banks();
      bank_independence();
      random_mix();
      repeat (3) idle_cycle();                       // Drain the last ack
      if (expected_q.size() == 0) begin
         $display("Test completed successfully");
         $finish;
      end else begin
         $display("%0d requests never received an ack", expected_q.size());
         abort_test();
      end
   end

endmodule

/* dual_bank_sram.f */
+incdir+hdl
hdl/sram_pkg.sv
hdl/sram_bus_if.sv
hdl/sram_bank.sv
hdl/wb_sram_interface.sv
hdl/bank_decoder.sv
hdl/dual_bank_sram.sv
verification/dual_bank_sram_sva.sv
verification/dual_bank_sram_tb.sv

/* Makefile */
# Verilator simulation of the dual-bank SRAM subsystem

VERILATOR ?= verilator
TOP       ?= dual_bank_sram_tb
FILELIST  ?= dual_bank_sram.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Test completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
